//--- hdl/rvseed_pkg.sv
`default_nettype none

package rvseed_pkg;

    localparam int XLEN       = 64;
    localparam int REG_ADDR_W = 5;

    // access size as carried in the load/store encoding
    typedef enum logic [1:0] {
        SZ_BYTE   = 2'd0,
        SZ_HALF   = 2'd1,
        SZ_WORD   = 2'd2,
        SZ_DOUBLE = 2'd3
    } mem_size_e;

    // item handed over by execute
    typedef struct packed {
        logic                  valid;
        logic                  reg_wen;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       alu_res;     // result or effective address
        logic                  is_load;
        logic                  is_store;
        mem_size_e             size;
        logic                  load_unsigned;
        logic [XLEN-1:0]       store_data;  // unshifted rs2 value
        logic                  ebreak;
        logic [XLEN-1:0]       pc;
    } ex_mem_t;

    // item leaving the memory stage
    typedef struct packed {
        logic                  valid;
        logic                  reg_wen;
        logic [REG_ADDR_W-1:0] rd;
        logic                  from_mem;    // writeback takes load_data
        logic [XLEN-1:0]       alu_res;
        logic [XLEN-1:0]       load_data;   // already aligned and extended
        logic                  ebreak;
        logic [XLEN-1:0]       pc;
    } mem_wb_t;

    // data memory request
    typedef struct packed {
        logic            valid;
        logic            we;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;   // lane aligned
        logic [7:0]      wmask;   // one bit per byte lane
    } dmem_req_t;

    // register file write port
    typedef struct packed {
        logic                  en;
        logic [REG_ADDR_W-1:0] addr;
        logic [XLEN-1:0]       data;
    } reg_wr_t;

endpackage

`default_nettype wire

//--- hdl/pipe_reg.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_reg #(
    parameter type      payload_t = rvseed_pkg::mem_wb_t,
    parameter payload_t RST_VAL   = '0
) (
    input  wire logic     clk,
    input  wire logic     rst_n,
    input  wire logic     hold_i,    // keep current contents
    input  wire logic     flush_i,   // load a bubble
    input  wire payload_t d_i,
    output payload_t      q_o
);

    payload_t bubble;

    // reset image with the valid bit forced low
    always_comb begin
        bubble       = RST_VAL;
        bubble.valid = 1'b0;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q_o <= RST_VAL;
        end else if (hold_i) begin
            q_o <= q_o;
        end else if (flush_i) begin
            q_o <= bubble;
        end else begin
            q_o <= d_i;
        end
    end

    // a stage is either frozen or drained by its neighbours, never both
    hold_flush_excl_a: assert property (
        @(posedge clk) disable iff (!rst_n) !(hold_i && flush_i)
    ) else $error("pipe_reg: hold and flush asserted together");

endmodule

`default_nettype wire

//--- hdl/load_align.sv
`timescale 1ns/1ps
`default_nettype none

module load_align (
    input  wire logic [rvseed_pkg::XLEN-1:0] rdata_i,     // full aligned memory word
    input  wire logic [2:0]                  offset_i,    // byte offset in the word
    input  wire rvseed_pkg::mem_size_e       size_i,
    input  wire logic                        unsigned_i,
    output logic      [rvseed_pkg::XLEN-1:0] data_o
);

    localparam int W = rvseed_pkg::XLEN;

    logic [W-1:0] shifted;
    logic         misaligned;

    assign shifted = rdata_i >> {offset_i, 3'b000};   // addressed byte to lane 0

    always_comb begin
        data_o = shifted;
        unique case (size_i)
            rvseed_pkg::SZ_BYTE: begin
                if (unsigned_i) begin
                    data_o = {{(W-8){1'b0}}, shifted[7:0]};
                end else begin
                    data_o = {{(W-8){shifted[7]}}, shifted[7:0]};
                end
            end
            rvseed_pkg::SZ_HALF: begin
                if (unsigned_i) begin
                    data_o = {{(W-16){1'b0}}, shifted[15:0]};
                end else begin
                    data_o = {{(W-16){shifted[15]}}, shifted[15:0]};
                end
            end
            rvseed_pkg::SZ_WORD: begin
                if (unsigned_i) begin
                    data_o = {{(W-32){1'b0}}, shifted[31:0]};
                end else begin
                    data_o = {{(W-32){shifted[31]}}, shifted[31:0]};
                end
            end
            rvseed_pkg::SZ_DOUBLE: data_o = shifted;   // nothing to extend
        endcase
    end

    // natural alignment per access size
    assign misaligned = (size_i == rvseed_pkg::SZ_HALF   && offset_i[0])
                     || (size_i == rvseed_pkg::SZ_WORD   && offset_i[1:0] != 2'd0)
                     || (size_i == rvseed_pkg::SZ_DOUBLE && offset_i != 3'd0);

    always_comb begin
        align_a: assert #0 (!misaligned)
            else $error("load_align: offset %0d illegal for size %s", offset_i, size_i.name());
    end

endmodule

`default_nettype wire

//--- hdl/mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage (
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    input  wire rvseed_pkg::ex_mem_t         ex_mem_i,
    output rvseed_pkg::dmem_req_t            dmem_req_o,
    input  wire logic                        dmem_rsp_valid_i,   // one cycle pulse
    input  wire logic [rvseed_pkg::XLEN-1:0] dmem_rdata_i,
    output logic                             stall_o,
    output rvseed_pkg::mem_wb_t              mem_wb_o
);

    logic                        ld;
    logic                        st;
    logic [2:0]                  offset;
    logic [2:0]                  ld_offset;
    logic [7:0]                  size_mask;
    logic [rvseed_pkg::XLEN-1:0] load_data;

    assign ld     = ex_mem_i.valid & ex_mem_i.is_load;
    assign st     = ex_mem_i.valid & ex_mem_i.is_store;
    assign offset = ex_mem_i.alu_res[2:0];

    // byte enables before lane shift
    always_comb begin
        unique case (ex_mem_i.size)
            rvseed_pkg::SZ_BYTE:   size_mask = 8'h01;
            rvseed_pkg::SZ_HALF:   size_mask = 8'h03;
            rvseed_pkg::SZ_WORD:   size_mask = 8'h0f;
            rvseed_pkg::SZ_DOUBLE: size_mask = 8'hff;
        endcase
    end

    // loads stay on the bus until the response, stores go out once
    always_comb begin
        dmem_req_o.valid = ld | st;
        dmem_req_o.we    = st;
        dmem_req_o.addr  = ex_mem_i.alu_res;
        dmem_req_o.wdata = ex_mem_i.store_data << {offset, 3'b000};
        dmem_req_o.wmask = st ? (size_mask << offset) : 8'h00;
    end

    assign stall_o = ld & ~dmem_rsp_valid_i;   // waiting on load data

    // only a real load presents its offset to the aligner
    assign ld_offset = ld ? offset : 3'd0;

    load_align u_load_align (
        .rdata_i    (dmem_rdata_i),
        .offset_i   (ld_offset),
        .size_i     (ex_mem_i.size),
        .unsigned_i (ex_mem_i.load_unsigned),
        .data_o     (load_data)
    );

    always_comb begin
        mem_wb_o.valid     = ex_mem_i.valid & ~stall_o;   // bubble while stalled
        mem_wb_o.reg_wen   = ex_mem_i.reg_wen;
        mem_wb_o.rd        = ex_mem_i.rd;
        mem_wb_o.from_mem  = ex_mem_i.is_load;
        mem_wb_o.alu_res   = ex_mem_i.alu_res;
        mem_wb_o.load_data = load_data;
        mem_wb_o.ebreak    = ex_mem_i.ebreak;
        mem_wb_o.pc        = ex_mem_i.pc;
    end

    // EX/MEM must freeze the load while it waits
    req_stable_a: assert property (
        @(posedge clk) disable iff (!rst_n) stall_o |=> $stable(dmem_req_o)
    ) else $error("mem_stage: pending load request changed before response");

endmodule

`default_nettype wire

//--- hdl/wb_stage.sv
`timescale 1ns/1ps
`default_nettype none

module wb_stage (
    input  wire rvseed_pkg::mem_wb_t mem_wb_i,
    output rvseed_pkg::reg_wr_t      wr_o,
    output logic                     ebreak_o
);

    logic rd_nonzero;

    assign rd_nonzero = (mem_wb_i.rd != '0);

    always_comb begin
        // x0 writes are dropped here
        wr_o.en   = mem_wb_i.valid & mem_wb_i.reg_wen & rd_nonzero;
        wr_o.addr = mem_wb_i.rd;
        if (mem_wb_i.from_mem) begin
            wr_o.data = mem_wb_i.load_data;
        end else begin
            wr_o.data = mem_wb_i.alu_res;
        end
    end

    // retirement of ebreak, one cycle per item
    assign ebreak_o = mem_wb_i.valid & mem_wb_i.ebreak;

endmodule

`default_nettype wire

//--- hdl/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  wire logic                              clk,
    input  wire logic                              rst_n,
    input  wire rvseed_pkg::reg_wr_t               wr_i,
    input  wire logic [rvseed_pkg::REG_ADDR_W-1:0] rs1_addr_i,
    input  wire logic [rvseed_pkg::REG_ADDR_W-1:0] rs2_addr_i,
    output logic      [rvseed_pkg::XLEN-1:0]       rs1_data_o,
    output logic      [rvseed_pkg::XLEN-1:0]       rs2_data_o
);

    localparam int NUM_REGS = 2 ** rvseed_pkg::REG_ADDR_W;

    logic [rvseed_pkg::XLEN-1:0] regs [1:NUM_REGS-1];   // no storage for x0

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_i.en) begin
            regs[wr_i.addr] <= wr_i.data;
        end
    end

    // no bypass, a write shows up after the edge
    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

    // writeback already filters x0
    no_x0_write_a: assert property (
        @(posedge clk) disable iff (!rst_n) wr_i.en |-> (wr_i.addr != '0)
    ) else $error("reg_file: write enable with address zero");

endmodule

`default_nettype wire

//--- hdl/mem_wb_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_wb_top #(
    parameter logic [rvseed_pkg::XLEN-1:0] RESET_PC = 64'h0000_0000_8000_0000
) (
    input  wire logic                              clk,
    input  wire logic                              rst_n,
    input  wire rvseed_pkg::ex_mem_t               ex_i,
    output rvseed_pkg::dmem_req_t                  dmem_req_o,
    input  wire logic                              dmem_rsp_valid_i,
    input  wire logic [rvseed_pkg::XLEN-1:0]       dmem_rdata_i,
    output logic                                   stall_o,
    input  wire logic [rvseed_pkg::REG_ADDR_W-1:0] rs1_addr_i,
    input  wire logic [rvseed_pkg::REG_ADDR_W-1:0] rs2_addr_i,
    output logic      [rvseed_pkg::XLEN-1:0]       rs1_data_o,
    output logic      [rvseed_pkg::XLEN-1:0]       rs2_data_o,
    output logic                                   ebreak_o
);

    localparam rvseed_pkg::ex_mem_t EX_MEM_RST = '0;
    localparam rvseed_pkg::mem_wb_t MEM_WB_RST = '{pc: RESET_PC, default: '0};

    rvseed_pkg::ex_mem_t ex_mem_q;
    rvseed_pkg::mem_wb_t mem_wb_d;
    rvseed_pkg::mem_wb_t mem_wb_q;
    rvseed_pkg::reg_wr_t rf_wr;

    // EX/MEM freezes while a load waits
    pipe_reg #(
        .payload_t (rvseed_pkg::ex_mem_t),
        .RST_VAL   (EX_MEM_RST)
    ) u_ex_mem_reg (
        .clk     (clk),
        .rst_n   (rst_n),
        .hold_i  (stall_o),
        .flush_i (1'b0),
        .d_i     (ex_i),
        .q_o     (ex_mem_q)
    );

    mem_stage u_mem_stage (
        .clk              (clk),
        .rst_n            (rst_n),
        .ex_mem_i         (ex_mem_q),
        .dmem_req_o       (dmem_req_o),
        .dmem_rsp_valid_i (dmem_rsp_valid_i),
        .dmem_rdata_i     (dmem_rdata_i),
        .stall_o          (stall_o),
        .mem_wb_o         (mem_wb_d)
    );

    // MEM/WB takes bubbles during the stall
    pipe_reg #(
        .payload_t (rvseed_pkg::mem_wb_t),
        .RST_VAL   (MEM_WB_RST)
    ) u_mem_wb_reg (
        .clk     (clk),
        .rst_n   (rst_n),
        .hold_i  (1'b0),
        .flush_i (stall_o),
        .d_i     (mem_wb_d),
        .q_o     (mem_wb_q)
    );

    wb_stage u_wb_stage (
        .mem_wb_i (mem_wb_q),
        .wr_o     (rf_wr),
        .ebreak_o (ebreak_o)
    );

    reg_file u_reg_file (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr_i       (rf_wr),
        .rs1_addr_i (rs1_addr_i),
        .rs2_addr_i (rs2_addr_i),
        .rs1_data_o (rs1_data_o),
        .rs2_data_o (rs2_data_o)
    );

endmodule

`default_nettype wire

//--- sim/tb_mem_wb.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_wb;

    localparam int              XLEN       = rvseed_pkg::XLEN;
    localparam logic [XLEN-1:0] STORE_DATA = 64'h1122_3344_5566_7788;
    localparam logic [XLEN-1:0] LOAD_WORD  = 64'h7f80_1234_89ab_cd01;
    localparam logic [4:0]      FOLLOW_RD  = 5'd30;   // target of the ALU item queued behind loads

    typedef enum int {K_ALU, K_STORE, K_LOAD} kind_e;

    typedef struct {
        string                 name;
        kind_e                 kind;
        rvseed_pkg::ex_mem_t   ex;
        logic [XLEN-1:0]       mem_word;   // word the memory model answers with
        int                    lat;        // base response delay in cycles
        logic                  wr;         // rd is expected to change
        logic [XLEN-1:0]       exp_val;
        rvseed_pkg::dmem_req_t exp_req;
    } entry_t;

    logic                  clk;
    logic                  rst_n;
    rvseed_pkg::ex_mem_t   ex_i;
    rvseed_pkg::dmem_req_t dmem_req;
    logic                  dmem_rsp_valid;
    logic [XLEN-1:0]       dmem_rdata;
    logic                  stall;
    logic [4:0]            rs1_addr;
    logic [4:0]            rs2_addr;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;
    logic                  ebreak;

    entry_t          tests[$];
    logic [XLEN-1:0] rf_model [32];   // expected architectural state
    logic [31:0]     lfsr;
    int              errors       = 0;
    int              passed       = 0;
    int              failed       = 0;
    int              cycles       = 0;
    int              cycle_limit  = 0;
    int              ebreak_total = 0;

    mem_wb_top #(
        .RESET_PC (64'h0000_0000_8000_0000)
    ) DUT (
        .clk              (clk),
        .rst_n            (rst_n),
        .ex_i             (ex_i),
        .dmem_req_o       (dmem_req),
        .dmem_rsp_valid_i (dmem_rsp_valid),
        .dmem_rdata_i     (dmem_rdata),
        .stall_o          (stall),
        .rs1_addr_i       (rs1_addr),
        .rs2_addr_i       (rs2_addr),
        .rs1_data_o       (rs1_data),
        .rs2_data_o       (rs2_data),
        .ebreak_o         (ebreak)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, the table did not complete", cycles);
            $display("Test failed");
            $finish;
        end
    end

    always @(negedge clk) begin
        if (rst_n && ebreak) ebreak_total <= ebreak_total + 1;   // one count per pulse
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) return (s >> 1) ^ 32'hd000_0001;
        return s >> 1;
    endfunction

    task automatic random_bits(input int n, output int v);
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = (v << 1) | int'(lfsr[0]);
        end
    endtask

    task automatic check_req(input string sig, input rvseed_pkg::dmem_req_t got,
                             input rvseed_pkg::dmem_req_t exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", sig, got, exp);
            errors++;
        end
    endtask

    task automatic check_data(input string sig, input logic [XLEN-1:0] got,
                              input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", sig, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(input string sig, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", sig, got, exp);
            errors++;
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    function automatic rvseed_pkg::ex_mem_t base_item();
        rvseed_pkg::ex_mem_t ex;
        ex       = '0;
        ex.valid = 1'b1;
        ex.pc    = 64'h8000_0000 + 64'(4 * tests.size());
        return ex;
    endfunction

    task automatic add_entry(input string name, input kind_e kind, input rvseed_pkg::ex_mem_t ex,
                             input logic wr, input logic [XLEN-1:0] exp,
                             input rvseed_pkg::dmem_req_t req);
        entry_t e;
        e.name     = name;
        e.kind     = kind;
        e.ex       = ex;
        e.mem_word = (kind == K_LOAD) ? LOAD_WORD : '0;
        e.lat      = tests.size() % 2;
        e.wr       = wr;
        e.exp_val  = exp;
        e.exp_req  = req;
        tests.push_back(e);
    endtask

    task automatic add_alu(input string name, input logic [4:0] rd, input logic wen,
                           input logic [XLEN-1:0] val, input logic brk, input logic wr);
        rvseed_pkg::ex_mem_t ex;
        ex         = base_item();
        ex.rd      = rd;
        ex.reg_wen = wen;
        ex.alu_res = val;
        ex.ebreak  = brk;
        add_entry(name, K_ALU, ex, wr, val, '0);
    endtask

    task automatic add_store(input rvseed_pkg::mem_size_e size, input logic [2:0] off,
                             input logic [7:0] mask, input logic [XLEN-1:0] wdata);
        rvseed_pkg::ex_mem_t   ex;
        rvseed_pkg::dmem_req_t req;
        ex            = base_item();
        ex.is_store   = 1'b1;
        ex.size       = size;
        ex.rd         = 5'd3;   // must stay untouched
        ex.alu_res    = 64'h1000 + 64'(off);
        ex.store_data = STORE_DATA;
        req.valid     = 1'b1;
        req.we        = 1'b1;
        req.addr      = ex.alu_res;
        req.wdata     = wdata;
        req.wmask     = mask;
        add_entry($sformatf("store %s off %0d", size.name(), off), K_STORE, ex, 1'b0, '0, req);
    endtask

    task automatic add_load(input rvseed_pkg::mem_size_e size, input logic uns,
                            input logic [2:0] off, input logic [4:0] rd,
                            input logic [XLEN-1:0] exp);
        rvseed_pkg::ex_mem_t   ex;
        rvseed_pkg::dmem_req_t req;
        ex               = base_item();
        ex.is_load       = 1'b1;
        ex.reg_wen       = 1'b1;
        ex.rd            = rd;
        ex.size          = size;
        ex.load_unsigned = uns;
        ex.alu_res       = 64'h2000 + 64'(off);
        req              = '0;
        req.valid        = 1'b1;
        req.addr         = ex.alu_res;
        add_entry($sformatf("load %s%s off %0d", size.name(), uns ? " unsigned" : "", off),
                  K_LOAD, ex, 1'b1, exp, req);
    endtask

    task automatic build_tests();
        add_alu("alu write x5", 5'd5, 1'b1, 64'hdead_beef_0123_4567, 1'b0, 1'b1);
        add_alu("alu write x31", 5'd31, 1'b1, 64'h0123_4567_89ab_cdef, 1'b0, 1'b1);
        add_alu("alu rd x0", 5'd0, 1'b1, 64'hffff_ffff_ffff_ffff, 1'b0, 1'b0);
        add_alu("alu reg_wen low", 5'd5, 1'b0, 64'h5555_aaaa_5555_aaaa, 1'b0, 1'b0);
        add_alu("ebreak", 5'd0, 1'b0, '0, 1'b1, 1'b0);
        // byte lanes follow the address offset
        add_store(rvseed_pkg::SZ_BYTE, 3'd0, 8'h01, 64'h1122_3344_5566_7788);
        add_store(rvseed_pkg::SZ_BYTE, 3'd1, 8'h02, 64'h2233_4455_6677_8800);
        add_store(rvseed_pkg::SZ_BYTE, 3'd2, 8'h04, 64'h3344_5566_7788_0000);
        add_store(rvseed_pkg::SZ_BYTE, 3'd3, 8'h08, 64'h4455_6677_8800_0000);
        add_store(rvseed_pkg::SZ_BYTE, 3'd4, 8'h10, 64'h5566_7788_0000_0000);
        add_store(rvseed_pkg::SZ_BYTE, 3'd5, 8'h20, 64'h6677_8800_0000_0000);
        add_store(rvseed_pkg::SZ_BYTE, 3'd6, 8'h40, 64'h7788_0000_0000_0000);
        add_store(rvseed_pkg::SZ_BYTE, 3'd7, 8'h80, 64'h8800_0000_0000_0000);
        add_store(rvseed_pkg::SZ_HALF, 3'd0, 8'h03, 64'h1122_3344_5566_7788);
        add_store(rvseed_pkg::SZ_HALF, 3'd2, 8'h0c, 64'h3344_5566_7788_0000);
        add_store(rvseed_pkg::SZ_HALF, 3'd4, 8'h30, 64'h5566_7788_0000_0000);
        add_store(rvseed_pkg::SZ_HALF, 3'd6, 8'hc0, 64'h7788_0000_0000_0000);
        add_store(rvseed_pkg::SZ_WORD, 3'd0, 8'h0f, 64'h1122_3344_5566_7788);
        add_store(rvseed_pkg::SZ_WORD, 3'd4, 8'hf0, 64'h5566_7788_0000_0000);
        add_store(rvseed_pkg::SZ_DOUBLE, 3'd0, 8'hff, 64'h1122_3344_5566_7788);
        // expected values taken from the bytes of LOAD_WORD
        add_load(rvseed_pkg::SZ_BYTE, 1'b0, 3'd0, 5'd6, 64'h0000_0000_0000_0001);
        add_load(rvseed_pkg::SZ_BYTE, 1'b0, 3'd1, 5'd7, 64'hffff_ffff_ffff_ffcd);
        add_load(rvseed_pkg::SZ_BYTE, 1'b1, 3'd1, 5'd8, 64'h0000_0000_0000_00cd);
        add_load(rvseed_pkg::SZ_BYTE, 1'b0, 3'd6, 5'd9, 64'hffff_ffff_ffff_ff80);
        add_load(rvseed_pkg::SZ_BYTE, 1'b1, 3'd6, 5'd10, 64'h0000_0000_0000_0080);
        add_load(rvseed_pkg::SZ_BYTE, 1'b0, 3'd7, 5'd11, 64'h0000_0000_0000_007f);
        add_load(rvseed_pkg::SZ_HALF, 1'b0, 3'd0, 5'd12, 64'hffff_ffff_ffff_cd01);
        add_load(rvseed_pkg::SZ_HALF, 1'b1, 3'd0, 5'd13, 64'h0000_0000_0000_cd01);
        add_load(rvseed_pkg::SZ_HALF, 1'b0, 3'd2, 5'd14, 64'hffff_ffff_ffff_89ab);
        add_load(rvseed_pkg::SZ_HALF, 1'b0, 3'd4, 5'd15, 64'h0000_0000_0000_1234);
        add_load(rvseed_pkg::SZ_HALF, 1'b0, 3'd6, 5'd16, 64'h0000_0000_0000_7f80);
        add_load(rvseed_pkg::SZ_WORD, 1'b0, 3'd0, 5'd17, 64'hffff_ffff_89ab_cd01);
        add_load(rvseed_pkg::SZ_WORD, 1'b1, 3'd0, 5'd18, 64'h0000_0000_89ab_cd01);
        add_load(rvseed_pkg::SZ_WORD, 1'b0, 3'd4, 5'd19, 64'h0000_0000_7f80_1234);
        add_load(rvseed_pkg::SZ_DOUBLE, 1'b0, 3'd0, 5'd20, 64'h7f80_1234_89ab_cd01);
    endtask

    task automatic run_entry(input int idx, input entry_t e);
        int                    start_err;
        int                    start_brk;
        int                    extra;
        int                    wait_n;
        rvseed_pkg::dmem_req_t req0;
        rvseed_pkg::ex_mem_t   follow;
        logic [XLEN-1:0]       follow_val;
        start_err = errors;
        start_brk = ebreak_total;
        next_cycle();
        rs1_addr = e.ex.rd;
        ex_i     = e.ex;
        next_cycle();   // item sampled into EX/MEM
        ex_i = '0;
        if (e.kind == K_LOAD) begin
            follow_val     = 64'h0f0f_0000_0000_0000 | 64'(idx);
            follow         = base_item();
            follow.reg_wen = 1'b1;
            follow.rd      = FOLLOW_RD;
            follow.alu_res = follow_val;
            ex_i           = follow;   // held at ex_i until the stall drops
            random_bits(2, extra);
            wait_n = e.lat + extra;
            for (int i = 0; i <= wait_n; i++) begin
                if (i == wait_n) begin
                    dmem_rsp_valid = 1'b1;
                    dmem_rdata     = e.mem_word;
                end
                @(negedge clk);
                if (i == 0) begin
                    req0 = dmem_req;
                    check_bit("dmem_req_o.valid", dmem_req.valid, 1'b1);
                    check_bit("dmem_req_o.we", dmem_req.we, 1'b0);
                    check_data("dmem_req_o.addr", dmem_req.addr, e.exp_req.addr);
                end
                check_req("dmem_req_o", dmem_req, req0);
                check_bit("stall_o", stall, i != wait_n);
                check_data("x30 while load pending", rs2_data, rf_model[FOLLOW_RD]);
                next_cycle();
            end
            dmem_rsp_valid = 1'b0;
            dmem_rdata     = '0;
            ex_i           = '0;
            next_cycle();   // load written
            @(negedge clk);
            check_data("x30 at load write", rs2_data, rf_model[FOLLOW_RD]);
            next_cycle();
            @(negedge clk);
            check_data("x30 after load", rs2_data, follow_val);
            rf_model[FOLLOW_RD] = follow_val;
        end else begin
            @(negedge clk);
            if (e.kind == K_STORE) check_req("dmem_req_o", dmem_req, e.exp_req);
            else check_bit("dmem_req_o.valid", dmem_req.valid, 1'b0);
            check_bit("stall_o", stall, 1'b0);
            next_cycle();
            next_cycle();   // write edge
            @(negedge clk);
        end
        if (e.wr) rf_model[e.ex.rd] = e.exp_val;
        check_data($sformatf("x%0d", e.ex.rd), rs1_data, rf_model[e.ex.rd]);
        check_data("ebreak_o pulses", 64'(ebreak_total - start_brk),
                   e.ex.ebreak ? 64'd1 : 64'd0);
        if (errors == start_err) begin
            passed++;
            $display("PASS test %0d: %s", idx, e.name);
        end else begin
            failed++;
            $display("FAIL test %0d: %s", idx, e.name);
        end
    endtask

    initial begin
        int start_err;
        lfsr           = 32'h6b51da85;
        rst_n          = 1'b0;
        ex_i           = '0;
        dmem_rsp_valid = 1'b0;
        dmem_rdata     = '0;
        rs1_addr       = '0;
        rs2_addr       = FOLLOW_RD;
        for (int i = 0; i < 32; i++) rf_model[i] = '0;
        build_tests();
        cycle_limit = 40 * tests.size() + 16;
        repeat (16) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(negedge clk);
        start_err = errors;
        check_bit("stall_o", stall, 1'b0);
        check_bit("ebreak_o", ebreak, 1'b0);
        check_bit("dmem_req_o.valid", dmem_req.valid, 1'b0);
        check_data("x30", rs2_data, '0);
        $display("%s reset state", (errors == start_err) ? "PASS" : "FAIL");
        foreach (tests[i]) run_entry(i, tests[i]);
        $display("tests run %0d, passed %0d, failed %0d, check errors %0d",
                 tests.size(), passed, failed, errors);
        if (failed == 0 && errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
hdl/rvseed_pkg.sv
hdl/pipe_reg.sv
hdl/load_align.sv
hdl/mem_stage.sv
hdl/wb_stage.sv
hdl/reg_file.sv
hdl/mem_wb_top.sv
sim/tb_mem_wb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_mem_wb
FILELIST   := project.f
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall
BUILD_DIR  := obj_dir
LOG        := sim.log
FAIL_MSG   := Test failed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# a crashed simulation counts as a failure as well
run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported a failure"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
